// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = muldiv_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
src/muldiv_pkg.sv
src/arb_pkg.sv
src/md_divide.sv
src/md_multiply.sv
src/muldiv_unit.sv
src/md_arbiter.sv
src/muldiv_top.sv
sim/md_arbiter_chk.sv
sim/muldiv_scoreboard.sv
sim/muldiv_tb.sv

// File: sim/md_arbiter_chk.sv
module md_arbiter_chk (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  c0_req_ready,
   input  logic  c1_req_ready,
   input  logic  c0_resp_valid,
   input  logic  c1_resp_valid,
   input  logic  u_resp_valid,
   input  logic  busy
);

   timeunit 1ns;
   timeprecision 1ps;

   // Grant selects one client only
   ready_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n) !(c0_req_ready && c1_req_ready)
   ) else $error("c0 and c1 req_ready high together");

   resp_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n) !(c0_resp_valid && c1_resp_valid)
   ) else $error("c0 and c1 response pulses together");

   // A result only comes back for an operation in flight
   resp_needs_owner: assert property (
      @(posedge clk) disable iff (!rst_n) u_resp_valid |-> busy
   ) else $error("unit response while the arbiter is idle");

endmodule

// File: sim/muldiv_scoreboard.sv
module muldiv_scoreboard (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req_valid [arb_pkg::n_clients],
   input  logic                            req_ready [arb_pkg::n_clients],
   input  logic [muldiv_pkg::funct_w-1:0]  req_op [arb_pkg::n_clients],
   input  logic [muldiv_pkg::xlen-1:0]     req_a [arb_pkg::n_clients],
   input  logic [muldiv_pkg::xlen-1:0]     req_b [arb_pkg::n_clients],
   input  logic                            resp_valid [arb_pkg::n_clients],
   input  logic [muldiv_pkg::xlen-1:0]     resp_result [arb_pkg::n_clients],
   output int                              pass_count,
   output int                              fail_count
);

   timeunit 1ns;
   timeprecision 1ps;

   logic                            pending [arb_pkg::n_clients];
   logic [muldiv_pkg::funct_w-1:0]  op_q [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     a_q [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     b_q [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     expect_q [arb_pkg::n_clients];
   int                              accept_cycle [arb_pkg::n_clients];
   int                              test_no [arb_pkg::n_clients];
   int                              cycle = 0;
   int                              passes = 0;
   int                              fails = 0;
   int                              last_served;
   bit                              have_last;

   assign pass_count = passes;
   assign fail_count = fails;

   function automatic string op_name(input logic [muldiv_pkg::funct_w-1:0] op);
      case (op)
         muldiv_pkg::op_mul:    return "MUL";
         muldiv_pkg::op_mulh:   return "MULH";
         muldiv_pkg::op_mulhsu: return "MULHSU";
         muldiv_pkg::op_mulhu:  return "MULHU";
         muldiv_pkg::op_div:    return "DIV";
         muldiv_pkg::op_divu:   return "DIVU";
         muldiv_pkg::op_rem:    return "REM";
         muldiv_pkg::op_remu:   return "REMU";
         default:               return "unknown";
      endcase
   endfunction

   function automatic bit is_divide(input logic [muldiv_pkg::funct_w-1:0] op);
      return op == muldiv_pkg::op_div || op == muldiv_pkg::op_divu ||
             op == muldiv_pkg::op_rem || op == muldiv_pkg::op_remu;
   endfunction

   function automatic bit is_overflow(
      input logic [muldiv_pkg::funct_w-1:0] op,
      input logic [muldiv_pkg::xlen-1:0]    a,
      input logic [muldiv_pkg::xlen-1:0]    b
   );
      return (op == muldiv_pkg::op_div || op == muldiv_pkg::op_rem) &&
             a == 32'h8000_0000 && b == 32'hffff_ffff;
   endfunction

   // RV32M reference arithmetic
   function automatic logic [muldiv_pkg::xlen-1:0] model_result(
      input logic [muldiv_pkg::funct_w-1:0] op,
      input logic [muldiv_pkg::xlen-1:0]    a,
      input logic [muldiv_pkg::xlen-1:0]    b
   );
      longint       sa;
      longint       sb;
      longint       ua;
      longint       ub;
      logic [63:0]  p;
      int           qi;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      ua = longint'(a);
      ub = longint'(b);
      case (op)
         muldiv_pkg::op_mul:    p = sa * sb;
         muldiv_pkg::op_mulh:   p = sa * sb;
         muldiv_pkg::op_mulhsu: p = sa * ub;
         default:               p = ua * ub;
      endcase
      if (op == muldiv_pkg::op_mul)
         return p[31:0];
      if (!is_divide(op))
         return p[63:32];
      if (b == '0)
         return (op == muldiv_pkg::op_div || op == muldiv_pkg::op_divu) ? '1 : a;
      if (is_overflow(op, a, b))
         return (op == muldiv_pkg::op_div) ? a : '0;
      // SV division truncates and the remainder takes the dividend's sign
      case (op)
         muldiv_pkg::op_div:  qi = $signed(a) / $signed(b);
         muldiv_pkg::op_rem:  qi = $signed(a) % $signed(b);
         muldiv_pkg::op_divu: qi = a / b;
         default:             qi = a % b;
      endcase
      return qi;
   endfunction

   function automatic bit latency_ok(input int i, input int lat);
      if (!is_divide(op_q[i]))
         return lat == 1;
      if (b_q[i] == '0 || is_overflow(op_q[i], a_q[i], b_q[i]))
         return lat == 3;
      return lat >= 3 && lat <= 34;
   endfunction

   task automatic report_error(input string msg);
      $display("error: %s", msg);
      fails++;
   endtask

   task automatic check_response(input int i);
      string name;
      int    lat;
      if (!pending[i]) begin
         report_error($sformatf("client %0d got a response with no request outstanding", i));
         return;
      end
      name = $sformatf("c%0d #%0d %s a=%h b=%h", i, test_no[i], op_name(op_q[i]),
                       a_q[i], b_q[i]);
      lat = cycle - accept_cycle[i];
      if (resp_result[i] !== expect_q[i]) begin
         $display("mismatch %s: expected %h, actual %h", name, expect_q[i], resp_result[i]);
         fails++;
      end else if (!latency_ok(i, lat)) begin
         $display("late %s: response came %0d cycles after acceptance", name, lat);
         fails++;
      end else begin
         $display("ok %s: %h after %0d cycles", name, resp_result[i], lat);
         passes++;
      end
      pending[i] = 1'b0;
   endtask

   task automatic record_request(input int i);
      // Round robin when both ask at an idle arbiter
      if (req_valid[0] && req_valid[1] && have_last && i == last_served)
         report_error($sformatf("client %0d served twice in a row while both requested", i));
      pending[i] = 1'b1;
      op_q[i] = req_op[i];
      a_q[i] = req_a[i];
      b_q[i] = req_b[i];
      expect_q[i] = model_result(req_op[i], req_a[i], req_b[i]);
      accept_cycle[i] = cycle;
      test_no[i]++;
      last_served = i;
      have_last = 1'b1;
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < arb_pkg::n_clients; i++) begin
            if (resp_valid[i])
               report_error($sformatf("client %0d response pulse during reset", i));
            pending[i] = 1'b0;
            test_no[i] = 0;
         end
         have_last = 1'b0;
      end else begin
         if (req_ready[0] && req_ready[1])
            report_error("both clients see req_ready high in the same cycle");
         if (resp_valid[0] && resp_valid[1])
            report_error("both clients got a response pulse in the same cycle");
         for (int i = 0; i < arb_pkg::n_clients; i++) begin
            if (pending[i] && req_ready[i])
               report_error($sformatf("client %0d req_ready high before its response", i));
            if (resp_valid[i])
               check_response(i);
            if (req_valid[i] && req_ready[i])
               record_request(i);
         end
      end
      cycle++;
   end

endmodule

// File: sim/muldiv_tb.sv
module muldiv_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_tests = 300;
   localparam int n_corner = 4;
   localparam int half_period = 50;
   localparam int reset_cycles = 16;
   // Worst divide is 34 cycles, plus accept cycle and request gap
   localparam int limit_cycles = reset_cycles + 2 * n_tests * (34 + 6) + 100;

   logic                            clk;
   logic                            rst_n;
   logic                            req_valid [arb_pkg::n_clients];
   logic                            req_ready [arb_pkg::n_clients];
   logic [muldiv_pkg::funct_w-1:0]  req_op [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     req_a [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     req_b [arb_pkg::n_clients];
   logic                            resp_valid [arb_pkg::n_clients];
   logic [muldiv_pkg::xlen-1:0]     resp_result [arb_pkg::n_clients];

   logic                            took [arb_pkg::n_clients];
   logic                            got_resp [arb_pkg::n_clients];
   int                              phase [arb_pkg::n_clients];
   int                              gap [arb_pkg::n_clients];
   int                              issued [arb_pkg::n_clients];
   int                              pass_count;
   int                              fail_count;
   integer                          seed;

   always #half_period clk = ~clk;

   muldiv_top uut (
      .clk            (clk),
      .rst_n          (rst_n),
      .c0_req_valid   (req_valid[0]),
      .c0_req_ready   (req_ready[0]),
      .c0_req_op      (req_op[0]),
      .c0_req_a       (req_a[0]),
      .c0_req_b       (req_b[0]),
      .c0_resp_valid  (resp_valid[0]),
      .c0_resp_result (resp_result[0]),
      .c1_req_valid   (req_valid[1]),
      .c1_req_ready   (req_ready[1]),
      .c1_req_op      (req_op[1]),
      .c1_req_a       (req_a[1]),
      .c1_req_b       (req_b[1]),
      .c1_resp_valid  (resp_valid[1]),
      .c1_resp_result (resp_result[1])
   );

   muldiv_scoreboard sb (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_op      (req_op),
      .req_a       (req_a),
      .req_b       (req_b),
      .resp_valid  (resp_valid),
      .resp_result (resp_result),
      .pass_count  (pass_count),
      .fail_count  (fail_count)
   );

   bind md_arbiter md_arbiter_chk arb_chk (
      .clk           (clk),
      .rst_n         (rst_n),
      .c0_req_ready  (c0_req_ready),
      .c1_req_ready  (c1_req_ready),
      .c0_resp_valid (c0_resp_valid),
      .c1_resp_valid (c1_resp_valid),
      .u_resp_valid  (u_resp_valid),
      .busy          (busy_q)
   );

   // Handshakes as seen at the last rising edge
   always @(posedge clk) begin
      for (int i = 0; i < arb_pkg::n_clients; i++) begin
         took[i] <= req_valid[i] & req_ready[i];
         got_resp[i] <= resp_valid[i];
      end
   end

   function automatic logic [muldiv_pkg::xlen-1:0] pick_operand();
      logic [31:0] r;
      logic [31:0] v;
      r = $random(seed);
      v = $random(seed);
      case (r[3:0])
         4'd0:    return '0;
         4'd1:    return 32'd1;
         4'd2:    return '1;
         4'd3:    return 32'h8000_0000;
         4'd4:    return 32'h7fff_ffff;
         // Small magnitudes give long divides
         4'd5, 4'd6, 4'd7: return v >> r[8:4];
         default: return v;
      endcase
   endfunction

   // Overflow, zero divisor, zero dividend, divisor of one, extreme products
   function automatic logic [2+2*muldiv_pkg::xlen:0] corner_request(input int n);
      case (n)
         0:       return {muldiv_pkg::op_div, 32'h8000_0000, 32'hffff_ffff};
         1:       return {muldiv_pkg::op_rem, 32'h8000_0000, 32'hffff_ffff};
         2:       return {muldiv_pkg::op_divu, 32'h1234_5678, 32'h0000_0000};
         3:       return {muldiv_pkg::op_rem, 32'h8765_4321, 32'h0000_0000};
         4:       return {muldiv_pkg::op_div, 32'h0000_0000, 32'h0000_0007};
         5:       return {muldiv_pkg::op_remu, 32'hdead_beef, 32'h0000_0001};
         6:       return {muldiv_pkg::op_mulh, 32'h8000_0000, 32'h8000_0000};
         default: return {muldiv_pkg::op_mulhsu, 32'hffff_ffff, 32'hffff_ffff};
      endcase
   endfunction

   task automatic step_client(input int i);
      logic [31:0] r;
      case (phase[i])
         0: begin
            if (issued[i] < n_tests) begin
               if (gap[i] > 0) begin
                  gap[i]--;
               end else begin
                  r = $random(seed);
                  if (issued[i] < n_corner) begin
                     {req_op[i], req_a[i], req_b[i]} = corner_request(2 * issued[i] + i);
                  end else begin
                     req_op[i] = r[2:0];
                     req_a[i] = pick_operand();
                     req_b[i] = pick_operand();
                  end
                  req_valid[i] = 1'b1;
                  issued[i]++;
                  phase[i] = 1;
               end
            end
         end
         1: begin
            if (took[i]) begin
               req_valid[i] = 1'b0;
               phase[i] = 2;
            end
         end
         default: begin
            if (got_resp[i]) begin
               r = $random(seed);
               gap[i] = {30'd0, r[1:0]};
               phase[i] = 0;
            end
         end
      endcase
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      seed = 86;
      for (int i = 0; i < arb_pkg::n_clients; i++) begin
         req_valid[i] = 1'b0;
         req_op[i] = '0;
         req_a[i] = '0;
         req_b[i] = '0;
         phase[i] = 0;
         gap[i] = 0;
         issued[i] = 0;
      end
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      while (issued[0] < n_tests || issued[1] < n_tests || phase[0] != 0 || phase[1] != 0) begin
         @(negedge clk);
         for (int i = 0; i < arb_pkg::n_clients; i++)
            step_client(i);
      end
      repeat (4) @(posedge clk);
      $display("tests %0d, passed %0d, failed %0d", 2 * n_tests, pass_count, fail_count);
      if (fail_count == 0 && pass_count == 2 * n_tests)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: responses still outstanding after %0d cycles", limit_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: src/arb_pkg.sv
package arb_pkg;

   // Peer clients sharing the unit
   localparam int n_clients = 2;

   // Width of a client index
   localparam int client_w = $clog2(n_clients);

endpackage

// File: src/md_arbiter.sv
module md_arbiter (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            c0_req_valid,
   input  logic                            c1_req_valid,
   input  logic [muldiv_pkg::funct_w-1:0]  c0_req_op,
   input  logic [muldiv_pkg::funct_w-1:0]  c1_req_op,
   input  logic [muldiv_pkg::xlen-1:0]     c0_req_a,
   input  logic [muldiv_pkg::xlen-1:0]     c0_req_b,
   input  logic [muldiv_pkg::xlen-1:0]     c1_req_a,
   input  logic [muldiv_pkg::xlen-1:0]     c1_req_b,
   output logic                            c0_req_ready,
   output logic                            c1_req_ready,
   output logic                            c0_resp_valid,
   output logic                            c1_resp_valid,
   output logic [muldiv_pkg::xlen-1:0]     c0_resp_result,
   output logic [muldiv_pkg::xlen-1:0]     c1_resp_result,
   output logic                            u_req_valid,
   output logic [muldiv_pkg::funct_w-1:0]  u_req_op,
   output logic [muldiv_pkg::xlen-1:0]     u_req_a,
   output logic [muldiv_pkg::xlen-1:0]     u_req_b,
   input  logic                            u_req_ready,
   input  logic                            u_resp_valid,
   input  logic [muldiv_pkg::xlen-1:0]     u_resp_result
);

   logic [arb_pkg::n_clients-1:0]   req_vec;
   logic [arb_pkg::client_w-1:0]    grant;
   logic [arb_pkg::client_w-1:0]    owner_q;
   logic [arb_pkg::client_w-1:0]    last_q;
   logic                            busy_q;
   logic                            accept;

   assign req_vec = {c1_req_valid, c0_req_valid};

   // Both asking goes to the one not served last
   always_comb begin
      if (&req_vec)
         grant = last_q + 1'b1;
      else if (req_vec[1])
         grant = '1;
      else
         grant = '0;
   end

   assign u_req_valid = ~busy_q & req_vec[grant];
   assign u_req_op = (grant == '0) ? c0_req_op : c1_req_op;
   assign u_req_a = (grant == '0) ? c0_req_a : c1_req_a;
   assign u_req_b = (grant == '0) ? c0_req_b : c1_req_b;

   assign c0_req_ready = ~busy_q & u_req_ready & (grant == '0);
   assign c1_req_ready = ~busy_q & u_req_ready & (grant == '1);
   assign accept = u_req_valid & u_req_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         owner_q <= '0;
         last_q <= '1;
      end else if (accept) begin
         busy_q <= 1'b1;
         owner_q <= grant;
         last_q <= grant;
      end else if (u_resp_valid) begin
         busy_q <= 1'b0;
      end
   end

   // Only the owner sees the pulse
   assign c0_resp_valid = u_resp_valid & busy_q & (owner_q == '0);
   assign c1_resp_valid = u_resp_valid & busy_q & (owner_q == '1);
   assign c0_resp_result = u_resp_result;
   assign c1_resp_result = u_resp_result;

endmodule

// File: src/md_divide.sv
module md_divide (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   input  logic                          a_signed,
   input  logic                          b_signed,
   input  logic                          rem_sel,
   input  logic [muldiv_pkg::xlen-1:0]   a,
   input  logic [muldiv_pkg::xlen-1:0]   b,
   output logic                          ready,
   output logic                          done,
   output logic [muldiv_pkg::xlen-1:0]   result
);

   typedef enum logic [1:0] {s_idle, s_compute, s_setup_output, s_done} state_t;

   state_t                             state;
   state_t                             next_state;

   logic [muldiv_pkg::xlen-1:0]        abs_a;
   logic [muldiv_pkg::xlen-1:0]        abs_b;
   logic                               sign_a;
   logic                               sign_b;
   logic                               div_zero;
   logic                               overflow;
   logic [muldiv_pkg::cnt_w-1:0]       clz_a;
   logic [muldiv_pkg::cnt_w-1:0]       clz_b;
   logic [muldiv_pkg::cnt_w-1:0]       shift_d;

   logic [muldiv_pkg::xlen-1:0]        rem_q;
   logic [muldiv_pkg::xlen-1:0]        div_q;
   logic [muldiv_pkg::xlen-1:0]        quot_q;
   logic [muldiv_pkg::cnt_w-1:0]       cnt_q;
   logic                               neg_q;
   logic                               rem_op_q;
   logic                               special_q;

   logic [muldiv_pkg::xlen-1:0]        quot_bit;
   logic [muldiv_pkg::xlen-1:0]        picked;
   logic [muldiv_pkg::xlen-1:0]        final_val;

   // Leading zeros, xlen for an all-zero value
   function automatic logic [muldiv_pkg::cnt_w-1:0] clz(input logic [muldiv_pkg::xlen-1:0] v);
      logic [muldiv_pkg::cnt_w-1:0] n;
      logic                         found;
      n = '0;
      found = 1'b0;
      for (int i = muldiv_pkg::xlen - 1; i >= 0; i--) begin
         if (v[i])
            found = 1'b1;
         else if (!found)
            n = n + 1'b1;
      end
      return n;
   endfunction

   assign sign_a = a_signed & a[muldiv_pkg::xlen-1];
   assign sign_b = b_signed & b[muldiv_pkg::xlen-1];
   assign abs_a = sign_a ? -a : a;
   assign abs_b = sign_b ? -b : b;

   assign div_zero = ~|b;
   // Most negative value over minus one
   assign overflow = sign_a & b_signed & (&b) & ~|a[muldiv_pkg::xlen-2:0];

   assign clz_a = clz(abs_a);
   assign clz_b = clz(abs_b);
   assign shift_d = (abs_a < abs_b) ? '0 : clz_b - clz_a;

   assign quot_bit = {{(muldiv_pkg::xlen-1){1'b0}}, 1'b1} << cnt_q;
   assign picked = rem_op_q ? rem_q : quot_q;
   assign final_val = neg_q ? -picked : picked;

   assign ready = (state == s_idle);
   assign done = (state == s_done);
   assign result = quot_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= s_idle;
      else
         state <= next_state;
   end

   always_comb begin
      case (state)
         s_idle:         next_state = start ? s_compute : s_idle;
         s_compute:      next_state = (cnt_q == '0) ? s_setup_output : s_compute;
         s_setup_output: next_state = s_done;
         default:        next_state = s_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      case (state)
         s_idle: begin
            if (start) begin
               rem_op_q <= rem_sel;
               if (div_zero || overflow) begin
                  // RISC-V results are known up front, one idle pass only
                  special_q <= 1'b1;
                  neg_q <= 1'b0;
                  cnt_q <= '0;
                  quot_q <= div_zero ? '1 : a;
                  rem_q <= div_zero ? a : '0;
               end else begin
                  special_q <= 1'b0;
                  neg_q <= rem_sel ? sign_a : sign_a ^ sign_b;
                  cnt_q <= shift_d;
                  quot_q <= '0;
                  rem_q <= abs_a;
                  div_q <= abs_b << shift_d;
               end
            end
         end
         s_compute: begin
            cnt_q <= cnt_q - 1'b1;
            div_q <= div_q >> 1;
            if (!special_q && rem_q >= div_q) begin
               rem_q <= rem_q - div_q;
               quot_q <= quot_q | quot_bit;
            end
         end
         s_setup_output: begin
            quot_q <= final_val;
         end
         default: ;
      endcase
   end

endmodule

// File: src/md_multiply.sv
module md_multiply (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   input  logic                          a_signed,
   input  logic                          b_signed,
   input  logic                          high_sel,
   input  logic [muldiv_pkg::xlen-1:0]   a,
   input  logic [muldiv_pkg::xlen-1:0]   b,
   output logic                          done,
   output logic [muldiv_pkg::xlen-1:0]   result
);

   logic [2*muldiv_pkg::xlen-1:0]   a_ext;
   logic [2*muldiv_pkg::xlen-1:0]   b_ext;
   logic [2*muldiv_pkg::xlen-1:0]   product;
   logic                            done_q;
   logic [muldiv_pkg::xlen-1:0]     result_q;

   // Each operand extended by its own signedness
   assign a_ext = {{muldiv_pkg::xlen{a_signed & a[muldiv_pkg::xlen-1]}}, a};
   assign b_ext = {{muldiv_pkg::xlen{b_signed & b[muldiv_pkg::xlen-1]}}, b};

   // Low 2*xlen bits are exact for any mix of signedness
   assign product = a_ext * b_ext;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         done_q <= 1'b0;
      else
         done_q <= start;
   end

   always_ff @(posedge clk) begin
      if (start) begin
         if (high_sel)
            result_q <= product[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
         else
            result_q <= product[muldiv_pkg::xlen-1:0];
      end
   end

   assign done = done_q;
   assign result = result_q;

endmodule

// File: src/muldiv_pkg.sv
package muldiv_pkg;

   // Operand and result width
   localparam int xlen = 32;
   localparam int funct_w = 3;

   // RV32M funct3 order, top bit selects the divider
   localparam logic [funct_w-1:0] op_mul    = 3'd0;
   localparam logic [funct_w-1:0] op_mulh   = 3'd1;
   localparam logic [funct_w-1:0] op_mulhsu = 3'd2;
   localparam logic [funct_w-1:0] op_mulhu  = 3'd3;
   localparam logic [funct_w-1:0] op_div    = 3'd4;
   localparam logic [funct_w-1:0] op_divu   = 3'd5;
   localparam logic [funct_w-1:0] op_rem    = 3'd6;
   localparam logic [funct_w-1:0] op_remu   = 3'd7;

   // Divider shift counter, must also hold xlen for a zero operand
   localparam int cnt_w = $clog2(xlen) + 1;

endpackage

// File: src/muldiv_top.sv
module muldiv_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            c0_req_valid,
   output logic                            c0_req_ready,
   input  logic [muldiv_pkg::funct_w-1:0]  c0_req_op,
   input  logic [muldiv_pkg::xlen-1:0]     c0_req_a,
   input  logic [muldiv_pkg::xlen-1:0]     c0_req_b,
   output logic                            c0_resp_valid,
   output logic [muldiv_pkg::xlen-1:0]     c0_resp_result,
   input  logic                            c1_req_valid,
   output logic                            c1_req_ready,
   input  logic [muldiv_pkg::funct_w-1:0]  c1_req_op,
   input  logic [muldiv_pkg::xlen-1:0]     c1_req_a,
   input  logic [muldiv_pkg::xlen-1:0]     c1_req_b,
   output logic                            c1_resp_valid,
   output logic [muldiv_pkg::xlen-1:0]     c1_resp_result
);

   logic                            u_req_valid;
   logic                            u_req_ready;
   logic [muldiv_pkg::funct_w-1:0]  u_req_op;
   logic [muldiv_pkg::xlen-1:0]     u_req_a;
   logic [muldiv_pkg::xlen-1:0]     u_req_b;
   logic                            u_resp_valid;
   logic [muldiv_pkg::xlen-1:0]     u_resp_result;

   md_arbiter arb (
      .clk            (clk),
      .rst_n          (rst_n),
      .c0_req_valid   (c0_req_valid),
      .c1_req_valid   (c1_req_valid),
      .c0_req_op      (c0_req_op),
      .c1_req_op      (c1_req_op),
      .c0_req_a       (c0_req_a),
      .c0_req_b       (c0_req_b),
      .c1_req_a       (c1_req_a),
      .c1_req_b       (c1_req_b),
      .c0_req_ready   (c0_req_ready),
      .c1_req_ready   (c1_req_ready),
      .c0_resp_valid  (c0_resp_valid),
      .c1_resp_valid  (c1_resp_valid),
      .c0_resp_result (c0_resp_result),
      .c1_resp_result (c1_resp_result),
      .u_req_valid    (u_req_valid),
      .u_req_op       (u_req_op),
      .u_req_a        (u_req_a),
      .u_req_b        (u_req_b),
      .u_req_ready    (u_req_ready),
      .u_resp_valid   (u_resp_valid),
      .u_resp_result  (u_resp_result)
   );

   muldiv_unit mdu (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (u_req_valid),
      .req_op      (u_req_op),
      .req_a       (u_req_a),
      .req_b       (u_req_b),
      .req_ready   (u_req_ready),
      .resp_valid  (u_resp_valid),
      .resp_result (u_resp_result)
   );

endmodule

// File: src/muldiv_unit.sv
module muldiv_unit (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req_valid,
   input  logic [muldiv_pkg::funct_w-1:0]  req_op,
   input  logic [muldiv_pkg::xlen-1:0]     req_a,
   input  logic [muldiv_pkg::xlen-1:0]     req_b,
   output logic                            req_ready,
   output logic                            resp_valid,
   output logic [muldiv_pkg::xlen-1:0]     resp_result
);

   logic                          is_div;
   logic                          a_signed;
   logic                          b_signed;
   logic                          high_sel;
   logic                          rem_sel;
   logic                          mul_start;
   logic                          div_start;
   logic                          mul_busy;
   logic                          mul_done;
   logic                          div_done;
   logic                          div_ready;
   logic [muldiv_pkg::xlen-1:0]   mul_result;
   logic [muldiv_pkg::xlen-1:0]   div_result;

   assign is_div = req_op[muldiv_pkg::funct_w-1];

   always_comb begin
      a_signed = 1'b0;
      b_signed = 1'b0;
      high_sel = 1'b0;
      rem_sel = 1'b0;
      case (req_op)
         muldiv_pkg::op_mul:    ;
         muldiv_pkg::op_mulh:   {a_signed, b_signed, high_sel} = 3'b111;
         muldiv_pkg::op_mulhsu: {a_signed, high_sel} = 2'b11;
         muldiv_pkg::op_mulhu:  high_sel = 1'b1;
         muldiv_pkg::op_div:    {a_signed, b_signed} = 2'b11;
         muldiv_pkg::op_divu:   ;
         muldiv_pkg::op_rem:    {a_signed, b_signed, rem_sel} = 3'b111;
         muldiv_pkg::op_remu:   rem_sel = 1'b1;
         default:               ;
      endcase
   end

   assign req_ready = div_ready & ~mul_busy;
   assign mul_start = req_valid & req_ready & ~is_div;
   assign div_start = req_valid & req_ready & is_div;

   // Covers the one cycle the multiplier holds an operation
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         mul_busy <= 1'b0;
      else if (mul_start)
         mul_busy <= 1'b1;
      else if (mul_done)
         mul_busy <= 1'b0;
   end

   md_multiply mul (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (mul_start),
      .a_signed (a_signed),
      .b_signed (b_signed),
      .high_sel (high_sel),
      .a        (req_a),
      .b        (req_b),
      .done     (mul_done),
      .result   (mul_result)
   );

   md_divide div (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (div_start),
      .a_signed (a_signed),
      .b_signed (b_signed),
      .rem_sel  (rem_sel),
      .a        (req_a),
      .b        (req_b),
      .ready    (div_ready),
      .done     (div_done),
      .result   (div_result)
   );

   assign resp_valid = mul_done | div_done;
   assign resp_result = mul_done ? mul_result : div_result;

endmodule
